//--- verilog/aluCore_settings.svh
`ifndef ALU_CORE_SETTINGS_SVH
`define ALU_CORE_SETTINGS_SVH

// Datapath widths for the ALU core

// Operand and result word
`define ALU_DATA_W 16

// Status flags X N Z V C
`define ALU_FLAG_N 5

// One-hot row vector, bit 0 is "no ALU row"
`define ALU_ROW_N 16

// Microcode column select, columns 1 to 4 in use
`define ALU_COL_W 3

`endif

//--- verilog/aluPkg.sv
`include "aluCore_settings.svh"

package aluPkg;

	// Operand / result word
	typedef logic [`ALU_DATA_W-1:0] aluData_t;

	// One-hot row decoded from ird
	typedef logic [`ALU_ROW_N-1:0] aluRow_t;

	// Microcode column
	typedef logic [`ALU_COL_W-1:0] aluCol_t;

	// Flags, X N Z V C from msb down
	typedef logic [`ALU_FLAG_N-1:0] ccrFlags_t;

	// Flag bit positions
	localparam int flagC = 0;
	localparam int flagV = 1;
	localparam int flagZ = 2;
	localparam int flagN = 3;
	localparam int flagX = 4;

	// ALU operations, opAnd first so reset gives zero
	typedef enum logic [4:0] {
		opAnd,
		opSub, opSubx, opAdd,
		opSub0,		// NOT is 0 - op - 1
		opOr, opEor,
		opSubc, opAddc, opAddx,
		opAsl, opAsr,
		opLsl, opLsr,
		opRol, opRor
	} aluOp_e;

	// Registered control, 29 bits
	typedef struct packed {
		aluOp_e oper;		// Latched on enT4
		ccrFlags_t ccrMask;	// Latched on enT4
		aluRow_t row;		// Latched on enT3
		logic isArX;		// ADDX/SUBX/NEGX, sticky Z
		logic noCcrEn;		// Flags untouched
		logic isByte;
	} aluCtrl_t;

endpackage

//--- verilog/aluControl.sv
`timescale 1ns/10ps

module aluControl (
	input logic clk,
	input logic rstN,
	input logic enT3,
	input logic enT4,
	input aluPkg::aluData_t ird,
	input aluPkg::aluCol_t aluColumn,
	input logic aluIsByte,
	input logic finish,
	output aluPkg::aluCtrl_t ctrl
);
	import aluPkg::*;

	// Mask encodings, X N Z V C
	localparam ccrFlags_t maskAll = 5'b11111;
	localparam ccrFlags_t maskNzvc = 5'b01111;	// C and V cleared by the op where needed
	localparam ccrFlags_t maskNz = 5'b01100;
	localparam ccrFlags_t maskZ = 5'b00100;
	localparam ccrFlags_t maskNone = 5'b00000;

	logic eaRdir;		// Dn or An direct
	logic eaAdir;		// An direct
	logic size11;
	logic [1:0] shiftType;
	logic [3:0] rowIdx;
	aluRow_t cRow;
	logic cIsArX;
	logic cNoCcrEn;
	aluOp_e nextOp;
	ccrFlags_t nextMask;
	ccrFlags_t mask1;

	assign eaRdir = (ird[5:4] == 2'b00);
	assign eaAdir = (ird[5:3] == 3'b001);
	assign size11 = ird[7] & ird[6];
	assign shiftType = size11 ? ird[10:9] : ird[4:3];	// Memory or register form

	// Row number from the opcode, 0 when no ALU row
	always_comb begin
		rowIdx = 4'd0;
		case (ird[15:12])
			4'h0: begin
				if (ird[8])
					rowIdx = ird[7] ? 4'd14 : 4'd13;	// Dynamic bit ops
				else begin
					case (ird[11:9])
						3'b000: rowIdx = 4'd14;	// ORI
						3'b001: rowIdx = 4'd4;	// ANDI
						3'b010: rowIdx = 4'd5;	// SUBI
						3'b011: rowIdx = 4'd2;	// ADDI
						3'b100: rowIdx = ird[7] ? 4'd14 : 4'd13;	// Static bit ops
						3'b101: rowIdx = 4'd13;	// EORI
						3'b110: rowIdx = 4'd6;	// CMPI
						default: rowIdx = 4'd0;
					endcase
				end
			end
			4'h1, 4'h2, 4'h3: rowIdx = 4'd2;	// MOVE
			4'h4: begin
				if (ird[8])
					rowIdx = 4'd6;	// CHK
				else begin
					case (ird[11:9])
						3'b000: rowIdx = 4'd10;	// NEGX
						3'b001: rowIdx = 4'd4;	// CLR
						3'b010: rowIdx = 4'd5;	// NEG
						3'b011: rowIdx = 4'd11;	// NOT
						3'b101: rowIdx = 4'd15;	// TST
						default: rowIdx = 4'd0;
					endcase
				end
			end
			4'h5: begin
				if (size11)
					rowIdx = 4'd15;	// Scc/DBcc
				else
					rowIdx = ird[8] ? 4'd5 : 4'd2;	// SUBQ / ADDQ
			end
			4'h7: rowIdx = 4'd2;	// MOVEQ
			4'h8: rowIdx = (size11 | (ird[8] & eaRdir)) ? 4'd0 : 4'd14;	// OR, no DIV/SBCD
			4'h9: rowIdx = (ird[8] & ~size11 & eaRdir) ? 4'd10 : 4'd5;	// SUBX or SUB/SUBA
			4'hb: rowIdx = (ird[8] & ~size11 & ~eaAdir) ? 4'd13 : 4'd6;	// EOR or CMP
			4'hc: rowIdx = (size11 | (ird[8] & eaRdir)) ? 4'd0 : 4'd4;	// AND, no MUL/ABCD
			4'hd: rowIdx = (ird[8] & ~size11 & eaRdir) ? 4'd12 : 4'd2;	// ADDX or ADD/ADDA
			4'he: begin
				case ({shiftType, ird[8]})
					3'd0: rowIdx = 4'd2;	// ASR
					3'd1: rowIdx = 4'd3;	// ASL
					3'd2: rowIdx = 4'd5;	// LSR
					3'd3: rowIdx = 4'd4;	// LSL
					3'd6: rowIdx = 4'd10;	// ROR
					3'd7: rowIdx = 4'd9;	// ROL
					default: rowIdx = 4'd0;	// ROXL/ROXR not supported
				endcase
			end
			default: rowIdx = 4'd0;
		endcase
	end

	assign cRow = aluRow_t'(1) << rowIdx;

	// Rows 10/12 in these groups are the X family only
	assign cIsArX = ((ird[15:12] == 4'h4) | (ird[15:12] == 4'h9) | (ird[15:12] == 4'hd))
		& ((rowIdx == 4'd10) | (rowIdx == 4'd12));

	// ADDA/SUBA, ADDQ/SUBQ to An, MOVEA
	assign cNoCcrEn = (ird[15] & ~ird[13] & ird[12] & size11)
		| ((ird[15:12] == 4'h5) & eaAdir)
		| ((~ird[15] & ~ird[14] & ird[13]) & (ird[8:6] == 3'b001));

	// Operation from registered row and column
	always_comb begin
		nextOp = opAnd;	// Column 1, also don't care without a row
		if (aluColumn inside {3'd2, 3'd3, 3'd4}) begin
			case (1'b1)
				ctrl.row[2]: nextOp = (aluColumn == 3'd2) ? opAdd :
					(aluColumn == 3'd3) ? opAddc : opAsr;
				ctrl.row[3]: nextOp = (aluColumn == 3'd4) ? opAsl :
					(aluColumn == 3'd2) ? opAddx : opAdd;
				ctrl.row[4]: nextOp = (aluColumn == 3'd4) ? opLsl : opAnd;
				ctrl.row[5], ctrl.row[6]: nextOp = (aluColumn == 3'd2) ? opSub :
					(aluColumn == 3'd3) ? opSubc : opLsr;
				ctrl.row[9]: nextOp = (aluColumn == 3'd4) ? opRol : opSubx;
				ctrl.row[10]: nextOp = (aluColumn == 3'd2) ? opSubx :
					(aluColumn == 3'd3) ? opSubc : opRor;
				ctrl.row[11]: nextOp = opSub0;	// NOT
				ctrl.row[12]: nextOp = opAddx;
				ctrl.row[13]: nextOp = opEor;
				ctrl.row[14]: nextOp = (aluColumn == 3'd4) ? opEor : opOr;
				ctrl.row[15]: nextOp = (aluColumn == 3'd3) ? opAdd : opOr;	// ADD for DBcc
				default: nextOp = opAnd;
			endcase
		end
	end

	// Column 1 mask, Z only for bit ops while not finishing
	assign mask1 = finish ? maskNz : ((ctrl.row[13] | ctrl.row[14]) ? maskZ : maskNzvc);

	always_comb begin
		case (aluColumn)
			3'd1: nextMask = mask1;
			3'd2, 3'd3: begin
				case (1'b1)
					ctrl.row[2], ctrl.row[3], ctrl.row[5], ctrl.row[9],
					ctrl.row[10], ctrl.row[12]: nextMask = maskAll;
					ctrl.row[6], ctrl.row[11]: nextMask = maskNzvc;	// CMP keeps X
					ctrl.row[4], ctrl.row[13], ctrl.row[14]: nextMask = maskNzvc;	// Logic
					default: nextMask = maskNone;	// Row 15 too
				endcase
			end
			3'd4: begin
				case (1'b1)
					ctrl.row[2], ctrl.row[3], ctrl.row[4], ctrl.row[5]: nextMask = maskAll;	// Shifts
					ctrl.row[9], ctrl.row[10]: nextMask = maskNzvc;	// Rotates keep X
					default: nextMask = maskNone;
				endcase
			end
			default: nextMask = maskNone;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			ctrl <= '0;
		end else begin
			if (enT3) begin	// Opcode derived, T3
				ctrl.row <= cRow;
				ctrl.isArX <= cIsArX;
				ctrl.noCcrEn <= cNoCcrEn;
				ctrl.isByte <= aluIsByte;
			end
			if (enT4) begin	// Column derived, T4
				ctrl.oper <= nextOp;
				ctrl.ccrMask <= nextMask;
			end
		end
	end

endmodule

//--- verilog/aluArith.sv
`timescale 1ns/10ps
`include "aluCore_settings.svh"

module aluArith (
	input aluPkg::aluData_t aOperand,
	input aluPkg::aluData_t dOperand,
	input aluPkg::aluCtrl_t ctrl,
	input aluPkg::ccrFlags_t pswCcr,
	input logic coreC,
	output aluPkg::aluData_t arithResult,
	output logic arithCout,
	output logic arithOv
);
	import aluPkg::*;

	logic isAdd;
	logic addCin;
	logic [`ALU_DATA_W:0] sum;	// Extra bit for carry
	logic rMsb, dMsb, aMsb, sMsb;

	assign isAdd = (ctrl.oper == opAdd) | (ctrl.oper == opAddc) | (ctrl.oper == opAddx);

	always_comb begin
		case (ctrl.oper)
			opSub0: addCin = 1'b1;	// NOT = 0 - op - 1
			opAddc, opSubc: addCin = coreC;
			opAddx, opSubx: addCin = pswCcr[flagX];
			default: addCin = 1'b0;	// ADD/SUB
		endcase
	end

	// Subtract is data minus address operand
	always_comb begin
		if (ctrl.isByte)
			sum = isAdd ? {9'b0, dOperand[7:0]} + {9'b0, aOperand[7:0]} + addCin
				: {9'b0, dOperand[7:0]} - {9'b0, aOperand[7:0]} - addCin;
		else
			sum = isAdd ? {1'b0, dOperand} + {1'b0, aOperand} + addCin
				: {1'b0, dOperand} - {1'b0, aOperand} - addCin;
	end

	assign arithCout = ctrl.isByte ? sum[8] : sum[`ALU_DATA_W];

	// Signed overflow on size msb
	assign rMsb = ctrl.isByte ? sum[7] : sum[`ALU_DATA_W-1];
	assign dMsb = ctrl.isByte ? dOperand[7] : dOperand[`ALU_DATA_W-1];
	assign aMsb = ctrl.isByte ? aOperand[7] : aOperand[`ALU_DATA_W-1];
	assign sMsb = isAdd ? aMsb : ~aMsb;	// Effective source sign
	assign arithOv = (sMsb & dMsb & ~rMsb) | (~sMsb & ~dMsb & rMsb);

	always_comb begin
		case (ctrl.oper)
			opAnd: arithResult = aOperand & dOperand;
			opOr: arithResult = aOperand | dOperand;
			opEor: arithResult = aOperand ^ dOperand;
			default: arithResult = ctrl.isByte ? {{8{sum[7]}}, sum[7:0]}	// Sign extended
				: sum[`ALU_DATA_W-1:0];
		endcase
	end

endmodule

//--- verilog/aluShifter.sv
`timescale 1ns/10ps

module aluShifter (
	input aluPkg::aluData_t aOperand,
	input aluPkg::aluCtrl_t ctrl,
	input aluPkg::ccrFlags_t pswCcr,
	output aluPkg::aluData_t shiftResult,
	output logic shiftMsb
);
	import aluPkg::*;

	logic shiftRight;
	logic shiftCin;

	assign shiftMsb = ctrl.isByte ? aOperand[7] : aOperand[15];	// Size msb

	// Direction, left only for ASL/LSL/ROL
	assign shiftRight = (ctrl.oper == opAsr) | (ctrl.oper == opLsr) | (ctrl.oper == opRor);

	always_comb begin
		case (ctrl.oper)
			opLsl, opLsr, opAsl: shiftCin = 1'b0;
			opRol, opAsr: shiftCin = shiftMsb;	// Sign or wrap
			opRor: shiftCin = aOperand[0];
			default: shiftCin = pswCcr[flagX];	// Not a shift, result unused
		endcase
	end

	always_comb begin
		if (shiftRight) begin
			shiftResult = {shiftCin, aOperand[15:1]};
			if (ctrl.isByte)
				shiftResult[7] = shiftCin;	// Byte msb
		end else begin
			shiftResult = {aOperand[14:0], shiftCin};
		end
	end

endmodule

//--- verilog/aluFlags.sv
`timescale 1ns/10ps
`include "aluCore_settings.svh"

module aluFlags (
	input logic clk,
	input logic rstN,
	input logic enT3,
	input aluPkg::aluCol_t aluColumn,
	input logic finish,
	input logic init,
	input logic ftu2Ccr,
	input aluPkg::aluData_t ftu,
	input aluPkg::aluData_t aOperand,
	input aluPkg::aluCtrl_t ctrl,
	input aluPkg::aluData_t arithResult,
	input aluPkg::aluData_t shiftResult,
	input logic arithCout,
	input logic arithOv,
	input logic shiftMsb,
	output aluPkg::aluData_t aluOut,
	output logic [7:0] ccr,
	output aluPkg::ccrFlags_t pswCcr,
	output logic coreC,
	output logic ze
);
	import aluPkg::*;

	aluData_t result;
	ccrFlags_t ccrTemp;		// Unmasked new flags
	ccrFlags_t ccrMasked;
	ccrFlags_t ccrCore;		// Core copy, every executed op
	logic isShift;
	logic nextBit;

	assign isShift = ctrl.oper inside {opAsl, opAsr, opLsl, opLsr, opRol, opRor};
	assign result = isShift ? shiftResult : arithResult;
	assign nextBit = ctrl.isByte ? aOperand[6] : aOperand[14];	// Bit below msb

	always_comb begin
		ccrTemp = '0;
		ccrTemp[flagX] = pswCcr[flagX];	// Kept unless op sets it
		ccrTemp[flagZ] = ctrl.isByte ? ~(|result[7:0]) : ~(|result);
		ccrTemp[flagN] = ctrl.isByte ? result[7] : result[15];
		case (ctrl.oper)
			opAdd, opAddc, opAddx, opSub, opSubc, opSubx: begin
				ccrTemp[flagC] = arithCout;
				ccrTemp[flagX] = arithCout;
				ccrTemp[flagV] = arithOv;
			end
			opLsl: begin
				ccrTemp[flagC] = shiftMsb;
				ccrTemp[flagX] = shiftMsb;
			end
			opAsl: begin
				ccrTemp[flagC] = shiftMsb;
				ccrTemp[flagX] = shiftMsb;
				// V sticks if the msb changed on any step
				ccrTemp[flagV] = pswCcr[flagV] | (shiftMsb ^ nextBit);
			end
			opLsr, opAsr: begin
				ccrTemp[flagC] = aOperand[0];
				ccrTemp[flagX] = aOperand[0];
			end
			opRol: ccrTemp[flagC] = shiftMsb;	// X untouched
			opRor: ccrTemp[flagC] = aOperand[0];
			default: ccrTemp[flagC] = 1'b0;	// Logic ops and SUB0, C V clear
		endcase
	end

	// New bit where masked, old bit elsewhere
	always_comb begin
		ccrMasked = (ccrTemp & ctrl.ccrMask) | (pswCcr & ~ctrl.ccrMask);
		if (finish | ctrl.isArX)
			ccrMasked[flagZ] = ccrTemp[flagZ] & pswCcr[flagZ];	// Z can only clear
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			aluOut <= '0;
			ccrCore <= '0;
			pswCcr <= '0;
		end else if (enT3) begin
			if (|aluColumn) begin	// Column 0 is no ALU op
				aluOut <= result;
				ccrCore <= ccrTemp;
			end
			if (ftu2Ccr)
				pswCcr <= ftu[`ALU_FLAG_N-1:0];
			else if (~ctrl.noCcrEn & (finish | init))
				pswCcr <= ccrMasked;
		end
	end

	assign ccr = {{(8 - `ALU_FLAG_N){1'b0}}, pswCcr};
	assign coreC = ccrCore[flagC];
	assign ze = ~ccrCore[flagZ];	// High after reset

endmodule

//--- verilog/aluCore.sv
`timescale 1ns/10ps

module aluCore (
	input logic clk,
	input logic rstN,
	input logic enT3,
	input logic enT4,
	input aluPkg::aluData_t ird,
	input aluPkg::aluData_t alub,
	input aluPkg::aluData_t iDataBus,
	input aluPkg::aluData_t iAddrBus,
	input aluPkg::aluData_t ftu,
	input aluPkg::aluCol_t aluColumn,
	input logic [1:0] aluDataCtrl,
	input logic aluAddrCtrl,
	input logic aluIsByte,
	input logic finish,
	input logic init,
	input logic ftu2Ccr,
	output aluPkg::aluData_t aluOut,
	output logic [7:0] ccr,
	output logic ze
);
	import aluPkg::*;

	aluData_t aOperand, dOperand;
	aluCtrl_t ctrl;
	ccrFlags_t pswCcr;
	logic coreC;
	aluData_t arithResult, shiftResult;
	logic arithCout, arithOv, shiftMsb;

	// Address side operand
	assign aOperand = aluAddrCtrl ? alub : iAddrBus;

	// Data side operand
	always_comb begin
		case (aluDataCtrl)
			2'b00: dOperand = iDataBus;
			2'b11: dOperand = '1;
			default: dOperand = '0;	// 01, BCD path gone
		endcase
	end

	aluControl control_i (.clk(clk), .rstN(rstN), .enT3(enT3), .enT4(enT4), .ird(ird),
		.aluColumn(aluColumn), .aluIsByte(aluIsByte), .finish(finish), .ctrl(ctrl));

	aluArith arith_i (.aOperand(aOperand), .dOperand(dOperand), .ctrl(ctrl),
		.pswCcr(pswCcr), .coreC(coreC), .arithResult(arithResult),
		.arithCout(arithCout), .arithOv(arithOv));

	aluShifter shifter_i (.aOperand(aOperand), .ctrl(ctrl), .pswCcr(pswCcr),
		.shiftResult(shiftResult), .shiftMsb(shiftMsb));

	aluFlags flags_i (.clk(clk), .rstN(rstN), .enT3(enT3), .aluColumn(aluColumn),
		.finish(finish), .init(init), .ftu2Ccr(ftu2Ccr), .ftu(ftu), .aOperand(aOperand),
		.ctrl(ctrl), .arithResult(arithResult), .shiftResult(shiftResult),
		.arithCout(arithCout), .arithOv(arithOv), .shiftMsb(shiftMsb), .aluOut(aluOut),
		.ccr(ccr), .pswCcr(pswCcr), .coreC(coreC), .ze(ze));

endmodule

//--- testbench/aluCore_checker.sv
`timescale 1ns/10ps

module aluCoreChecker (
	input logic clk,
	input logic rstN,
	input logic enT3,
	input logic [15:0] aluOut,
	input logic [7:0] ccr
);
	logic seenT3;	// Any enT3 since reset
	logic upperFail = 1'b0;
	logic holdFail = 1'b0;
	logic resetFail = 1'b0;
	logic anyFail;

	assign anyFail = upperFail | holdFail | resetFail;	// Read by the testbench

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			seenT3 <= 1'b0;
		else if (enT3)
			seenT3 <= 1'b1;
	end

	// Only five flags exist
	upperZero: assert property (@(posedge clk) disable iff (!rstN) ccr[7:5] == 3'b000)
	else begin
		upperFail = 1'b1;
		$error("ccr bits 7:5 are not zero");
	end

	// Result and flags only move on an enT3 edge
	holdWithoutT3: assert property (@(posedge clk) disable iff (!rstN)
		!$past(enT3) |-> ($stable(aluOut) && $stable(ccr)))
	else begin
		holdFail = 1'b1;
		$error("aluOut or ccr changed without enT3 on the previous edge");
	end

	// Reset value held until the first T3
	zeroAfterReset: assert property (@(posedge clk) disable iff (!rstN)
		!seenT3 |-> (ccr == 8'h00))
	else begin
		resetFail = 1'b1;
		$error("ccr is not zero before the first enT3");
	end

endmodule

bind aluCore aluCoreChecker checker_i (.clk(clk), .rstN(rstN), .enT3(enT3), .aluOut(aluOut),
	.ccr(ccr));

//--- testbench/aluCoreTb.sv
`timescale 1ns/10ps

module aluCoreTb;
	localparam int maxCycles = 600;	// About 70 ops of 5 cycles, reset, margin

	logic clk;
	logic rstN;
	logic enT3;
	logic enT4;
	logic [15:0] ird;
	logic [15:0] alub;
	logic [15:0] iDataBus;
	logic [15:0] iAddrBus;
	logic [15:0] ftu;
	logic [2:0] aluColumn;
	logic [1:0] aluDataCtrl;
	logic aluAddrCtrl;
	logic aluIsByte;
	logic finish;
	logic init;
	logic ftu2Ccr;
	logic [15:0] aluOut;
	logic [7:0] ccr;
	logic ze;
	logic [31:0] rngState;
	logic [4:0] modelCcr;	// Expected X N Z V C
	int cycleCount;

	aluCore aluCore_i (.*);

	always #50 clk = ~clk;

	// Run limit
	always @(posedge clk) begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= maxCycles) begin
			$display("timeout after %0d cycles, the test sequence did not finish", cycleCount);
			failRun();
		end
	end

	task automatic failRun();
		$display("tests failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic checkValue(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		assert (actual === expected)
		else begin
			$display("mismatch %s: expected %h, actual %h", name, expected, actual);
			failRun();
		end
	endtask

	function automatic logic [31:0] nextRandom();
		logic [31:0] x;
		x = rngState;
		x = x ^ (x << 13);	// xorshift32
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rngState = x;
		return x;
	endfunction

	// {N, Z} of the chosen size
	function automatic logic [1:0] sizeNz(input logic [15:0] res, input logic byteSz);
		if (byteSz)
			return {res[7], res[7:0] == 8'h00};
		else
			return {res[15], res == 16'h0000};
	endfunction

	// {carry, overflow, result} from integer arithmetic
	function automatic logic [17:0] addSubRef(input logic doSub, input logic byteSz,
			input logic [15:0] a, input logic [15:0] d, input logic cin);
		int full;
		int ua;
		int ud;
		int sa;
		int sd;
		int ures;
		int sres;
		logic [15:0] res;
		full = byteSz ? 256 : 65536;
		ua = byteSz ? int'(a[7:0]) : int'(a);
		ud = byteSz ? int'(d[7:0]) : int'(d);
		sa = (ua >= full / 2) ? ua - full : ua;	// Signed view
		sd = (ud >= full / 2) ? ud - full : ud;
		ures = doSub ? ud - ua - int'(cin) : ud + ua + int'(cin);
		sres = doSub ? sd - sa - int'(cin) : sd + sa + int'(cin);
		res = 16'((ures + full) % full);
		if (byteSz)
			res = {{8{res[7]}}, res[7:0]};	// Sign extended byte
		return {(ures < 0) || (ures >= full), (sres < -(full / 2)) || (sres >= full / 2), res};
	endfunction

	function automatic logic [4:0] mergeFlags(input logic [4:0] newF, input logic [4:0] oldF,
			input logic [4:0] mask, input logic stickyZ);
		logic [4:0] merged;
		merged = (newF & mask) | (oldF & ~mask);
		if (stickyZ)
			merged[2] = newF[2] & oldF[2];	// Z only clears
		return merged;
	endfunction

	// Decode, T4 column, quiet cycle, execute, sample
	task automatic driveOp(input logic [15:0] irdVal, input logic [2:0] col, input logic byteSz,
			input logic [15:0] a, input logic [15:0] d, input logic useFinish);
		logic [31:0] r;
		r = nextRandom();
		@(posedge clk);
		#1;
		ird = irdVal;
		aluIsByte = byteSz;
		enT3 = 1'b1;
		@(posedge clk);
		#1;
		enT3 = 1'b0;
		enT4 = 1'b1;
		aluColumn = col;
		@(posedge clk);
		#1;
		enT4 = 1'b0;
		aluColumn = 3'd0;
		@(posedge clk);
		#1;
		enT3 = 1'b1;
		aluColumn = col;
		finish = useFinish;
		init = ~useFinish;
		aluAddrCtrl = r[16];	// Random address source, junk on the other
		alub = r[16] ? a : r[15:0];
		iAddrBus = r[16] ? r[15:0] : a;
		iDataBus = d;
		@(posedge clk);
		#1;
		enT3 = 1'b0;
		aluColumn = 3'd0;
		finish = 1'b0;
		init = 1'b0;
		@(negedge clk);
	endtask

	task automatic arithTest(input string name, input logic [15:0] irdVal, input logic doSub,
			input logic byteSz, input logic xFamily, input logic keepX, input logic useFinish,
			input logic noFlags, input logic [15:0] a, input logic [15:0] d);
		logic [17:0] r;
		logic [4:0] newF;
		logic [4:0] expF;
		logic cin;
		cin = xFamily & modelCcr[4];	// X family adds X
		driveOp(irdVal, 3'd2, byteSz, a, d, useFinish);
		r = addSubRef(doSub, byteSz, a, d, cin);
		newF = {r[17], sizeNz(r[15:0], byteSz), r[16], r[17]};
		expF = noFlags ? modelCcr :
			mergeFlags(newF, modelCcr, keepX ? 5'b01111 : 5'b11111, useFinish | xFamily);
		checkValue({name, " aluOut"}, r[15:0], aluOut);
		checkValue({name, " ccr"}, {11'h000, expF}, {8'h00, ccr});
		modelCcr = expF;
	endtask

	task automatic logicTest(input string name, input logic [15:0] irdVal, input logic [1:0] kind,
			input logic [15:0] a, input logic [15:0] d);
		logic [15:0] res;
		logic [4:0] expF;
		driveOp(irdVal, 3'd2, 1'b0, a, d, 1'b0);
		case (kind)
			2'd0: res = a & d;
			2'd1: res = a | d;
			default: res = a ^ d;
		endcase
		expF = {modelCcr[4], sizeNz(res, 1'b0), 2'b00};	// X kept, V C clear
		checkValue({name, " aluOut"}, res, aluOut);
		checkValue({name, " ccr"}, {11'h000, expF}, {8'h00, ccr});
		modelCcr = expF;
	endtask

	// Kind 0 ASL, 1 ASR, 2 LSL, 3 LSR, 4 ROL, 5 ROR
	task automatic shiftTest(input string name, input logic [15:0] irdVal, input logic [2:0] kind,
			input logic byteSz, input logic [15:0] a);
		logic msb;
		logic cin;
		logic left;
		logic [15:0] res;
		logic [15:0] keep;
		logic [4:0] expF;
		msb = byteSz ? a[7] : a[15];
		left = (kind == 3'd0) || (kind == 3'd2) || (kind == 3'd4);
		cin = (kind == 3'd1 || kind == 3'd4) ? msb : (kind == 3'd5) ? a[0] : 1'b0;
		res = left ? {a[14:0], cin} : {cin, a[15:1]};
		if (byteSz && !left)
			res[7] = cin;
		keep = byteSz ? 16'h00ff : 16'hffff;	// Low byte only for a byte step
		expF[0] = left ? msb : a[0];
		expF[4] = (kind >= 3'd4) ? modelCcr[4] : expF[0];	// Rotates keep X
		expF[3:2] = sizeNz(res, byteSz);
		expF[1] = (kind == 3'd0) ? (modelCcr[1] | (msb ^ (byteSz ? a[6] : a[14]))) : 1'b0;
		driveOp(irdVal, 3'd4, byteSz, a, 16'h0000, 1'b0);
		checkValue({name, " aluOut"}, res & keep, aluOut & keep);
		checkValue({name, " ccr"}, {11'h000, expF}, {8'h00, ccr});
		modelCcr = expF;
	endtask

	task automatic loadFlags(input logic [15:0] value);
		@(posedge clk);
		#1;
		ftu = value;
		ftu2Ccr = 1'b1;
		enT3 = 1'b1;
		@(posedge clk);
		#1;
		ftu2Ccr = 1'b0;
		enT3 = 1'b0;
		@(negedge clk);
		modelCcr = value[4:0];	// Low five ftu bits
		checkValue("ftu load ccr", {11'h000, modelCcr}, {8'h00, ccr});
	endtask

	initial begin
		logic [31:0] r;
		logic [15:0] a;
		logic [15:0] d;
		logic [15:0] sizeBits;
		clk = 1'b0;
		rstN = 1'b0;
		enT3 = 1'b0;
		enT4 = 1'b0;
		ird = 16'h0000;
		alub = 16'h0000;
		iDataBus = 16'h0000;
		iAddrBus = 16'h0000;
		ftu = 16'h0000;
		aluColumn = 3'd0;
		aluDataCtrl = 2'b00;	// Data operand from iDataBus
		aluAddrCtrl = 1'b0;
		aluIsByte = 1'b0;
		finish = 1'b0;
		init = 1'b0;
		ftu2Ccr = 1'b0;
		rngState = 32'h54d7d881;
		modelCcr = 5'b00000;
		cycleCount = 0;
		repeat (4) @(posedge clk);
		#1;
		rstN = 1'b1;
		@(negedge clk);
		checkValue("reset ccr", 16'h0000, {8'h00, ccr});
		checkValue("reset ze", 16'h0001, {15'h0000, ze});

		for (int i = 0; i < 10; i++) begin
			r = nextRandom();
			arithTest("ADD.W", 16'hD041, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, r[31:16], r[15:0]);
			r = nextRandom();
			arithTest("SUB.B", 16'h9001, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, r[31:16], r[15:0]);
		end
		for (int i = 0; i < 6; i++) begin
			r = nextRandom();
			arithTest("CMP.W", 16'hB041, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, r[31:16], r[15:0]);
			r = nextRandom();
			logicTest("AND", 16'hC041, 2'd0, r[31:16], r[15:0]);
			r = nextRandom();
			logicTest("OR", 16'h8041, 2'd1, r[31:16], r[15:0]);
			r = nextRandom();
			logicTest("EOR", 16'hB141, 2'd2, r[31:16], r[15:0]);
		end

		// Word pass then byte pass, register forms
		for (int s = 0; s < 2; s++) begin
			sizeBits = (s == 0) ? 16'h0040 : 16'h0000;
			r = nextRandom();
			shiftTest("ASL", 16'hE100 | sizeBits, 3'd0, s[0], r[15:0]);
			shiftTest("ASR", 16'hE000 | sizeBits, 3'd1, s[0], r[31:16]);
			r = nextRandom();
			shiftTest("LSL", 16'hE108 | sizeBits, 3'd2, s[0], r[15:0]);
			shiftTest("LSR", 16'hE008 | sizeBits, 3'd3, s[0], r[31:16]);
			r = nextRandom();
			shiftTest("ROL", 16'hE118 | sizeBits, 3'd4, s[0], r[15:0]);
			shiftTest("ROR", 16'hE018 | sizeBits, 3'd5, s[0], r[31:16]);
		end

		// ADDA leaves the flags alone
		for (int i = 0; i < 2; i++) begin
			r = nextRandom();
			loadFlags(r[31:16]);
			r = nextRandom();
			arithTest("ADDA.W", 16'hD0C1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, r[31:16], r[15:0]);
		end

		// Sticky Z across ADDX
		loadFlags(16'h0014);	// X and Z set
		r = nextRandom();
		d = r[15:0];
		a = 16'h0000 - d - {15'h0000, modelCcr[4]};
		arithTest("ADDX zero", 16'hD141, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, a, d);
		a = 16'h0001 - d - {15'h0000, modelCcr[4]};
		arithTest("ADDX nonzero", 16'hD141, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, a, d);
		a = 16'h0000 - d - {15'h0000, modelCcr[4]};
		arithTest("ADDX zero after clear", 16'hD141, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, a, d);

		if (aluCore_i.checker_i.anyFail) begin
			$display("a concurrent assertion in the bound checker fired");
			failRun();
		end else begin
			$display("all tests passed");
			$finish;
		end
	end

endmodule

//--- flist.f
+incdir+verilog
verilog/aluPkg.sv
verilog/aluControl.sv
verilog/aluArith.sv
verilog/aluShifter.sv
verilog/aluFlags.sv
verilog/aluCore.sv
testbench/aluCore_checker.sv
testbench/aluCoreTb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal -f flist.f --top-module aluCoreTb || exit 1
simOut=$(./obj_dir/ValuCoreTb)
echo "$simOut"
echo "$simOut" | grep -qx "all tests passed" && echo "PASS" || { echo "FAIL"; exit 1; }
